/* project.f */
mips_pkg.sv
mips_if.sv
alu.sv
register_file.sv
control_unit.sv
hazard_unit.sv
pipeline_datapath.sv
mips_cpu.sv
mips_cpu_checker.sv
mips_cpu_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mips_cpu_tb -f project.f -o mips_sim

status=0
./obj_dir/mips_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Verification failed" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without failure"

/* mips_testdata.txt */
// Word stream: program count, then per program the word count and words, expected v0,
// data word count and data words, store count and (address, data) pairs in program order
00000003
// Arithmetic chain with back-to-back forwarding
0000000d
24080005 24090003 01095021 01485823
01696024 018a6825 01a87026 012e782a
3c101234 36105670 020f1021 004e1021
00000008
1234567f
00000000
00000000
// Loads with immediate use, stores and reload
00000008
8c080000 8c090004 01091021 ac020008
8c0a0008 004a1021 ac02000c 00000008
00000246
00000002
00000100 00000023
00000002
00000008 00000123
0000000c 00000246
// Taken and not-taken BEQ and BNE, branch after load
00000010
24080007 24090007 11090001 24020bad
15090001 24420010 ac020010 8c0a0000
15480002 ac080014 24020bad 004a1021
10000001 24020bad ac020018 00000008
00000015
00000001
00000005
00000002
00000010 00000010
00000018 00000015

/* mips_cpu_tb.sv */
////////////////////////////////////////////////////////////
// Programs and expected results come from mips_testdata.txt.
// Memories are 256 words each, addressed by bits 9:2.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mips_cpu_tb;
	import mips_pkg::*;

	logic        clk;
	logic        rst;
	logic        clk_enable;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic [31:0] data_address;
	logic        data_write;
	logic        data_read;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;

	logic [31:0] td [512];
	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] store_addr [$];
	logic [31:0] store_data [$];
	logic [31:0] lcg_state;
	logic        pauses_on;
	logic        timed_out;
	int          ptr;
	int          cycles;
	int          value_errors;
	int          other_errors;

	mips_cpu dut_i (.*);

	assign instr_readdata = imem[instr_address[9:2]];
	// Idle read bus returns a marker word
	assign data_readdata = data_read ? dmem[data_address[9:2]] : 32'hdead_beef;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Unused data words differ at every address
	function automatic logic [31:0] fill_word(int i);
		return 32'hc0de_0000 ^ (32'(i) * 32'h0001_0193);
	endfunction

	function automatic logic is_halt(instr_t w);
		return w.r.op == op_rtype && w.r.funct == fn_jr && w.r.rs == 5'd0;
	endfunction

	function automatic logic [31:0] next_word();
		logic [31:0] w;
		w = td[ptr];
		ptr++;
		return w;
	endfunction

	// One rising edge; the memory model and the pause pattern follow it
	task automatic step();
		@(posedge clk);
		if (clk_enable && data_write) begin
			dmem[data_address[9:2]] = data_writedata;
			store_addr.push_back(data_address);
			store_data.push_back(data_writedata);
		end
		cycles++;
		if (pauses_on) begin
			lcg_state = lcg_next(lcg_state);
			clk_enable <= (lcg_state[17:16] != 2'b00);
		end else begin
			clk_enable <= 1'b1;
		end
	endtask

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic run_program(int num);
		int          nwords;
		int          ndata;
		int          nstores;
		int          drained;
		int          limit;
		logic [31:0] exp_v0;
		logic [31:0] exp_addr [$];
		logic [31:0] exp_data [$];
		nwords = next_word();
		for (int i = 0; i < 256; i++) begin
			if (i < nwords)
				imem[i] = next_word();
			else
				imem[i] = 32'd0;
		end
		if (nwords < 1 || !is_halt(imem[nwords - 1])) begin
			$display("Program %0d does not end with JR $zero", num);
			other_errors++;
		end
		exp_v0 = next_word();
		ndata = next_word();
		for (int i = 0; i < 256; i++) begin
			if (i < ndata)
				dmem[i] = next_word();
			else
				dmem[i] = fill_word(i);
		end
		nstores = next_word();
		for (int i = 0; i < nstores; i++) begin
			exp_addr.push_back(next_word());
			exp_data.push_back(next_word());
		end
		store_addr.delete();
		store_data.delete();

		pauses_on = 1'b0;
		rst <= 1'b1;
		repeat (8) step();
		check_value("register_v0", 32'd0, register_v0);
		if (active !== 1'b1) begin
			$display("ERROR at %0t ns: active expected 1, got %b", $time, active);
			value_errors++;
		end
		rst <= 1'b0;
		pauses_on = 1'b1;
		cycles = 0;
		limit = 200 * nwords + 100;

		while (active !== 1'b0 && cycles < limit)
			step();
		// Let the instructions ahead of the JR reach writeback
		drained = 0;
		while (drained < 5 && cycles < limit) begin
			step();
			if (clk_enable)
				drained++;
		end
		if (cycles >= limit) begin
			$display("Program %0d did not halt within %0d cycles", num, limit);
			timed_out = 1'b1;
			other_errors++;
			return;
		end

		check_value("register_v0", exp_v0, register_v0);
		if (store_addr.size() != nstores) begin
			$display("ERROR at %0t ns: store count expected %0d, got %0d",
				$time, nstores, store_addr.size());
			value_errors++;
		end else begin
			for (int i = 0; i < nstores; i++) begin
				check_value("data_address", exp_addr[i], store_addr[i]);
				check_value("data_writedata", exp_data[i], store_data[i]);
			end
		end
	endtask

	initial begin
		int nprog;
		rst <= 1'b1;
		clk_enable <= 1'b1;
		pauses_on = 1'b0;
		timed_out = 1'b0;
		lcg_state = 32'd37932;
		value_errors = 0;
		other_errors = 0;
		cycles = 0;
		ptr = 0;
		$readmemh("mips_testdata.txt", td);
		nprog = next_word();
		if (nprog <= 0) begin
			$display("The test data file holds no programs");
			other_errors++;
		end
		for (int p = 0; p < nprog && !timed_out; p++)
			run_program(p + 1);

		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* mips_cpu_checker.sv */
////////////////////////////////////////////////////////////
// Bound to mips_cpu. Checks memory strobes and PC freezing.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mips_cpu_checker (
	input logic        clk,
	input logic        rst,
	input logic        clk_enable,
	input logic        active,
	input logic        data_write,
	input logic        data_read,
	input logic [31:0] instr_address
);

	assert property (@(posedge clk) rst |=> !data_write)
		else $error("data_write high right after reset");

	assert property (@(posedge clk) disable iff (rst) !(data_write && data_read))
		else $error("data_write and data_read high together");

	// Paused core must not move the fetch PC
	assert property (@(posedge clk) disable iff (rst) !clk_enable |=> $stable(instr_address))
		else $error("instr_address changed while clk_enable was low");

	assert property (@(posedge clk) disable iff (rst) !active |=> $stable(instr_address))
		else $error("instr_address changed after halt");

endmodule

bind mips_cpu mips_cpu_checker chk_i (.*);

/* mips_cpu.sv */
////////////////////////////////////////////////////////////
// Five-stage MIPS core, Harvard bus. clk_enable low freezes
// every register. JR $zero halts and drops active.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mips_cpu (
	input  logic        clk,
	input  logic        rst,
	input  logic        clk_enable,
	output logic        active,
	output logic [31:0] register_v0,

	output logic [31:0] instr_address,
	input  logic [31:0] instr_readdata,

	output logic [31:0] data_address,
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata
);
	import mips_pkg::*;

	instr_t      instr_d;
	logic [4:0]  rf_ra1, rf_ra2, rf_wa;
	logic [31:0] rf_rd1, rf_rd2, rf_wd;
	logic        rf_we;
	alu_op_t     alu_op_e;
	logic [31:0] alu_a, alu_b, alu_y;

	ctrl_if   ctrl_bus ();
	hazard_if hz_bus ();

	pipeline_datapath path_i (
		.clk            (clk),
		.rst            (rst),
		.clk_enable     (clk_enable),
		.ctrl           (ctrl_bus.path),
		.hz             (hz_bus.path),
		.instr_d        (instr_d),
		.rf_ra1         (rf_ra1),
		.rf_ra2         (rf_ra2),
		.rf_rd1         (rf_rd1),
		.rf_rd2         (rf_rd2),
		.rf_we          (rf_we),
		.rf_wa          (rf_wa),
		.rf_wd          (rf_wd),
		.alu_op_e       (alu_op_e),
		.alu_a          (alu_a),
		.alu_b          (alu_b),
		.alu_y          (alu_y),
		.active         (active),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	control_unit ctrl_i (
		.instr (instr_d),
		.c     (ctrl_bus.ctrl)
	);

	hazard_unit hazard_i (
		.h (hz_bus.unit)
	);

	register_file regs_i (
		.clk (clk),
		.rst (rst),
		.ra1 (rf_ra1),
		.ra2 (rf_ra2),
		.rd1 (rf_rd1),
		.rd2 (rf_rd2),
		.we  (rf_we),
		.wa  (rf_wa),
		.wd  (rf_wd),
		.v0  (register_v0)
	);

	alu alu_i (
		.op (alu_op_e),
		.a  (alu_a),
		.b  (alu_b),
		.y  (alu_y)
	);

endmodule

/* pipeline_datapath.sv */
////////////////////////////////////////////////////////////
// Branches resolve in decode with no delay slot. A decoded
// JR $zero holds PC and the decode stage for good.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pipeline_datapath (
	input  logic              clk,
	input  logic              rst,
	input  logic              clk_enable,
	ctrl_if.path              ctrl,
	hazard_if.path            hz,
	output mips_pkg::instr_t  instr_d,
	output logic [4:0]        rf_ra1,
	output logic [4:0]        rf_ra2,
	input  logic [31:0]       rf_rd1,
	input  logic [31:0]       rf_rd2,
	output logic              rf_we,
	output logic [4:0]        rf_wa,
	output logic [31:0]       rf_wd,
	output mips_pkg::alu_op_t alu_op_e,
	output logic [31:0]       alu_a,
	output logic [31:0]       alu_b,
	input  logic [31:0]       alu_y,
	output logic              active,
	output logic [31:0]       instr_address,
	input  logic [31:0]       instr_readdata,
	output logic [31:0]       data_address,
	output logic              data_write,
	output logic              data_read,
	output logic [31:0]       data_writedata,
	input  logic [31:0]       data_readdata
);
	import mips_pkg::*;

	logic [31:0] pc, pc_plus4_f, pc_plus4_d;
	logic [31:0] imm_ext_d, opa_d, opb_d, target_d;
	logic        halt_d, taken_d, pc_src_d;

	logic        reg_write_e, mem_to_reg_e, mem_write_e, alu_src_imm_e, reg_dst_rd_e;
	logic [4:0]  rs_e, rt_e, rd_e, wreg_e;
	logic [31:0] rd1_e, rd2_e, imm_e, wdata_e;

	logic        reg_write_m, mem_to_reg_m, mem_write_m;
	logic [4:0]  wreg_m;
	logic [31:0] alu_out_m, wdata_m;

	logic        reg_write_w, mem_to_reg_w;
	logic [4:0]  wreg_w;
	logic [31:0] alu_out_w, rdata_w, result_w;

	function automatic logic [31:0] fwd_mux(fwd_sel_t sel, logic [31:0] rf_val,
		logic [31:0] mem_val, logic [31:0] wb_val);
		case (sel)
			fwd_memory:    return mem_val;
			fwd_writeback: return wb_val;
			default:       return rf_val;
		endcase
	endfunction

	assign instr_address = pc;
	assign pc_plus4_f = pc + 32'd4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (clk_enable && !hz.stall_f && !halt_d) begin
			pc <= pc_src_d ? target_d : pc_plus4_f;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			instr_d <= '0;
		end else if (clk_enable && !hz.stall_d && !halt_d) begin
			// Squash the instruction fetched behind a taken branch
			instr_d <= pc_src_d ? '0 : instr_readdata;
			pc_plus4_d <= pc_plus4_f;
		end
	end

	assign rf_ra1 = instr_d.r.rs;
	assign rf_ra2 = instr_d.r.rt;
	assign imm_ext_d = ctrl.imm_zero_ext ? {16'd0, instr_d.i.imm}
		: {{16{instr_d.i.imm[15]}}, instr_d.i.imm};
	assign opa_d = hz.fwd_a_d ? alu_out_m : rf_rd1;
	assign opb_d = hz.fwd_b_d ? alu_out_m : rf_rd2;
	assign halt_d = ctrl.jump_reg && (instr_d.r.rs == 5'd0);
	assign taken_d = ctrl.branch ? ((opa_d == opb_d) != ctrl.branch_ne)
		: (ctrl.jump_reg && !halt_d);
	// A stalled branch still has stale operands
	assign pc_src_d = taken_d && !hz.stall_d;
	assign target_d = ctrl.jump_reg ? opa_d : pc_plus4_d + {imm_ext_d[29:0], 2'b00};

	assign hz.rs_d = instr_d.r.rs;
	assign hz.rt_d = instr_d.r.rt;
	assign hz.branch_d = ctrl.branch || ctrl.jump_reg;

	always_ff @(posedge clk) begin
		if (rst || (clk_enable && hz.flush_e)) begin
			{reg_write_e, mem_to_reg_e, mem_write_e} <= '0;
			{alu_src_imm_e, reg_dst_rd_e} <= '0;
			alu_op_e <= alu_add;
			{rs_e, rt_e, rd_e} <= '0;
		end else if (clk_enable) begin
			reg_write_e <= ctrl.reg_write;
			mem_to_reg_e <= ctrl.mem_to_reg;
			mem_write_e <= ctrl.mem_write;
			alu_src_imm_e <= ctrl.alu_src_imm;
			reg_dst_rd_e <= ctrl.reg_dst_rd;
			alu_op_e <= ctrl.alu_op;
			rs_e <= instr_d.r.rs;
			rt_e <= instr_d.r.rt;
			rd_e <= instr_d.r.rd;
		end
	end

	always_ff @(posedge clk) begin
		if (clk_enable) begin
			rd1_e <= rf_rd1;
			rd2_e <= rf_rd2;
			imm_e <= imm_ext_d;
			alu_out_m <= alu_y;
			wdata_m <= wdata_e;
			alu_out_w <= alu_out_m;
			rdata_w <= data_readdata;
		end
	end

	assign wreg_e = reg_dst_rd_e ? rd_e : rt_e;
	assign alu_a = fwd_mux(hz.fwd_a_e, rd1_e, alu_out_m, result_w);
	assign wdata_e = fwd_mux(hz.fwd_b_e, rd2_e, alu_out_m, result_w);
	assign alu_b = alu_src_imm_e ? imm_e : wdata_e;

	assign hz.rs_e = rs_e;
	assign hz.rt_e = rt_e;
	assign hz.wreg_e = wreg_e;
	assign hz.reg_write_e = reg_write_e;
	assign hz.mem_to_reg_e = mem_to_reg_e;

	always_ff @(posedge clk) begin
		if (rst) begin
			{reg_write_m, mem_to_reg_m, mem_write_m} <= '0;
			wreg_m <= '0;
			{reg_write_w, mem_to_reg_w} <= '0;
			wreg_w <= '0;
		end else if (clk_enable) begin
			reg_write_m <= reg_write_e;
			mem_to_reg_m <= mem_to_reg_e;
			mem_write_m <= mem_write_e;
			wreg_m <= wreg_e;
			reg_write_w <= reg_write_m;
			mem_to_reg_w <= mem_to_reg_m;
			wreg_w <= wreg_m;
		end
	end

	assign data_address = alu_out_m;
	assign data_writedata = wdata_m;
	assign data_write = mem_write_m;
	assign data_read = mem_to_reg_m;

	assign hz.wreg_m = wreg_m;
	assign hz.reg_write_m = reg_write_m;
	assign hz.mem_to_reg_m = mem_to_reg_m;
	assign hz.wreg_w = wreg_w;
	assign hz.reg_write_w = reg_write_w;

	assign result_w = mem_to_reg_w ? rdata_w : alu_out_w;
	// Register file has no enable of its own
	assign rf_we = reg_write_w && clk_enable;
	assign rf_wa = wreg_w;
	assign rf_wd = result_w;

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b1;
		end else if (clk_enable && halt_d) begin
			active <= 1'b0;
		end
	end

endmodule

/* hazard_unit.sv */
////////////////////////////////////////////////////////////
// Forwarding and stall decisions. Register 0 never forwards.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module hazard_unit (
	hazard_if.unit h
);
	import mips_pkg::*;

	logic lw_stall;
	logic br_stall;

	// Memory stage wins over writeback
	function automatic fwd_sel_t exec_sel(logic [4:0] src, logic [4:0] wreg_m,
		logic we_m, logic [4:0] wreg_w, logic we_w);
		if (src != 5'd0 && we_m && wreg_m == src)
			return fwd_memory;
		if (src != 5'd0 && we_w && wreg_w == src)
			return fwd_writeback;
		return fwd_none;
	endfunction

	function automatic logic reads_d(logic [4:0] wreg, logic [4:0] rs, logic [4:0] rt);
		return (wreg != 5'd0) && (wreg == rs || wreg == rt);
	endfunction

	assign h.fwd_a_e = exec_sel(h.rs_e, h.wreg_m, h.reg_write_m, h.wreg_w, h.reg_write_w);
	assign h.fwd_b_e = exec_sel(h.rt_e, h.wreg_m, h.reg_write_m, h.wreg_w, h.reg_write_w);

	assign h.fwd_a_d = h.rs_d != 5'd0 && h.reg_write_m && h.wreg_m == h.rs_d;
	assign h.fwd_b_d = h.rt_d != 5'd0 && h.reg_write_m && h.wreg_m == h.rt_d;

	assign lw_stall = h.mem_to_reg_e && reads_d(h.wreg_e, h.rs_d, h.rt_d);

	// ALU result still in execute, or load data not back yet
	assign br_stall = h.branch_d &&
		((h.reg_write_e && reads_d(h.wreg_e, h.rs_d, h.rt_d)) ||
		(h.mem_to_reg_m && reads_d(h.wreg_m, h.rs_d, h.rt_d)));

	assign h.stall_f = lw_stall || br_stall;
	assign h.stall_d = lw_stall || br_stall;
	assign h.flush_e = lw_stall || br_stall;

endmodule

/* control_unit.sv */
////////////////////////////////////////////////////////////
// Decode-stage control. Unknown opcodes and functs write nothing.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module control_unit (
	input mips_pkg::instr_t instr,
	ctrl_if.ctrl            c
);
	import mips_pkg::*;

	always_comb begin
		c.reg_write = 1'b0;
		c.mem_to_reg = 1'b0;
		c.mem_write = 1'b0;
		c.alu_src_imm = 1'b0;
		c.reg_dst_rd = 1'b0;
		c.branch = 1'b0;
		c.branch_ne = 1'b0;
		c.imm_zero_ext = 1'b0;
		c.jump_reg = 1'b0;
		c.alu_op = alu_add;
		case (instr.r.op)
			op_rtype: begin
				c.reg_dst_rd = 1'b1;
				c.reg_write = 1'b1;
				case (instr.r.funct)
					fn_addu: c.alu_op = alu_add;
					fn_subu: c.alu_op = alu_sub;
					fn_and:  c.alu_op = alu_and;
					fn_or:   c.alu_op = alu_or;
					fn_xor:  c.alu_op = alu_xor;
					fn_slt:  c.alu_op = alu_slt;
					fn_jr: begin
						c.reg_write = 1'b0;
						c.jump_reg = 1'b1;
					end
					default: c.reg_write = 1'b0;
				endcase
			end
			op_addiu: {c.reg_write, c.alu_src_imm} = 2'b11;
			op_ori: begin
				{c.reg_write, c.alu_src_imm, c.imm_zero_ext} = 3'b111;
				c.alu_op = alu_or;
			end
			op_lui: begin
				{c.reg_write, c.alu_src_imm} = 2'b11;
				c.alu_op = alu_lui;
			end
			op_lw:  {c.reg_write, c.mem_to_reg, c.alu_src_imm} = 3'b111;
			op_sw:  {c.mem_write, c.alu_src_imm} = 2'b11;
			op_beq: c.branch = 1'b1;
			op_bne: {c.branch, c.branch_ne} = 2'b11;
			default: ;
		endcase
	end

endmodule

/* register_file.sv */
////////////////////////////////////////////////////////////
// Register 0 reads zero. A same-cycle write bypasses to reads.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module register_file (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	input  logic        we,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] v0
);
	import mips_pkg::*;

	logic [31:0] regs [32];
	logic        wr_live;

	assign wr_live = we && (wa != 5'd0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wa] <= wd;
		end
	end

	assign rd1 = (wr_live && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (wr_live && wa == ra2) ? wd : regs[ra2];
	assign v0 = regs[reg_v0];

endmodule

/* alu.sv */
////////////////////////////////////////////////////////////
// Execute-stage ALU. SLT compares signed, no overflow traps.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu (
	input  mips_pkg::alu_op_t op,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	output logic [31:0]       y
);
	import mips_pkg::*;

	always_comb begin
		case (op)
			alu_add: y = a + b;
			alu_sub: y = a - b;
			alu_and: y = a & b;
			alu_or:  y = a | b;
			alu_xor: y = a ^ b;
			alu_slt: y = {31'd0, $signed(a) < $signed(b)};
			// Upper immediate, a is ignored
			alu_lui: y = {b[15:0], 16'd0};
			default: y = '0;
		endcase
	end

endmodule

/* mips_if.sv */
////////////////////////////////////////////////////////////
// Control fields are valid while the instruction is in decode.
// Hazard signals are combinational within one cycle.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface ctrl_if;
	import mips_pkg::*;

	logic    reg_write;
	logic    mem_to_reg;
	logic    mem_write;
	logic    alu_src_imm;
	logic    reg_dst_rd;
	logic    branch;
	logic    branch_ne;
	logic    imm_zero_ext;
	logic    jump_reg;
	alu_op_t alu_op;

	modport ctrl (output reg_write, mem_to_reg, mem_write, alu_src_imm, reg_dst_rd,
		branch, branch_ne, imm_zero_ext, jump_reg, alu_op);
	modport path (input reg_write, mem_to_reg, mem_write, alu_src_imm, reg_dst_rd,
		branch, branch_ne, imm_zero_ext, jump_reg, alu_op);
endinterface

interface hazard_if;
	import mips_pkg::*;

	logic [4:0] rs_d, rt_d, rs_e, rt_e;
	logic [4:0] wreg_e, wreg_m, wreg_w;
	logic       reg_write_e, reg_write_m, reg_write_w;
	logic       mem_to_reg_e, mem_to_reg_m;
	// BEQ, BNE or JR in decode
	logic       branch_d;
	logic       stall_f, stall_d, flush_e;
	logic       fwd_a_d, fwd_b_d;
	fwd_sel_t   fwd_a_e, fwd_b_e;

	modport path (output rs_d, rt_d, rs_e, rt_e, wreg_e, wreg_m, wreg_w,
		reg_write_e, reg_write_m, reg_write_w, mem_to_reg_e, mem_to_reg_m, branch_d,
		input stall_f, stall_d, flush_e, fwd_a_d, fwd_b_d, fwd_a_e, fwd_b_e);
	modport unit (input rs_d, rt_d, rs_e, rt_e, wreg_e, wreg_m, wreg_w,
		reg_write_e, reg_write_m, reg_write_w, mem_to_reg_e, mem_to_reg_m, branch_d,
		output stall_f, stall_d, flush_e, fwd_a_d, fwd_b_d, fwd_a_e, fwd_b_e);
endinterface

/* mips_pkg.sv */
////////////////////////////////////////////////////////////
// Encodings for the supported MIPS subset only. No shifts,
// no HI/LO, no byte or half-word memory operations.
////////////////////////////////////////////////////////////
package mips_pkg;

	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lui   = 6'h0f;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;

	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_slt  = 6'h2a;
	localparam logic [5:0] fn_jr   = 6'h08;

	localparam logic [4:0] reg_v0 = 5'd2;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or,
		alu_xor, alu_slt, alu_lui
	} alu_op_t;

	// Source of an operand after forwarding
	typedef enum logic [1:0] {
		fwd_none      = 2'd0,
		fwd_writeback = 2'd1,
		fwd_memory    = 2'd2
	} fwd_sel_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_t;

endpackage
